/* logic/chess_pkg.sv */
`default_nettype none

package chess_pkg;

   localparam int axil_addr_w = 12;
   localparam int rank_count = 8;

   localparam logic [1:0] axi_resp_okay = 2'b00;

   // Bit 3 of a square is the colour
   localparam logic [2:0] kind_pawn = 3'd1;
   localparam logic [2:0] kind_knight = 3'd2;
   localparam logic [2:0] kind_bishop = 3'd3;
   localparam logic [2:0] kind_rook = 3'd4;
   localparam logic [2:0] kind_queen = 3'd5;
   localparam logic [2:0] kind_king = 3'd6;

   localparam logic signed [15:0] pawn_value = 16'sd1;
   localparam logic signed [15:0] knight_value = 16'sd3;
   localparam logic signed [15:0] bishop_value = 16'sd3;
   localparam logic signed [15:0] rook_value = 16'sd5;
   localparam logic signed [15:0] queen_value = 16'sd9;
   localparam logic signed [15:0] king_value = 16'sd0;

   localparam logic [7:0] reg_ctrl = 8'd0;
   localparam logic [7:0] reg_side = 8'd1;
   localparam logic [7:0] reg_board_base = 8'd8;    // Rank 1 .. rank 8
   localparam logic [7:0] reg_pop = 8'd16;
   localparam logic [7:0] reg_eval = 8'd17;
   localparam logic [7:0] reg_kings = 8'd18;

   localparam int ctrl_start = 0;
   localparam int ctrl_clear_done = 1;

   typedef struct packed {
      logic       black;
      logic [2:0] kind;
   } piece_t;

   typedef union packed {
      logic [31:0]                raw;
      piece_t [rank_count-1:0]    sq;    // sq[0] is the a-file
   } reg_word_u;

   typedef struct packed {
      logic       valid;
      logic [7:0] addr;
      reg_word_u  data;
   } wr_req_t;

   typedef struct packed {
      reg_word_u [rank_count-1:0] board;
      logic                       white_to_move;
   } eval_cfg_t;

   typedef struct packed {
      logic [5:0]         white_pop;
      logic [5:0]         black_pop;
      logic signed [15:0] eval;
      logic [3:0]         white_kings;
      logic [3:0]         black_kings;
      logic               illegal;
   } eval_result_t;

endpackage

`default_nettype wire

/* logic/axil_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_write_port
(
   input  wire logic                              clk,
   input  wire logic                              rst_n,
   input  wire logic [chess_pkg::axil_addr_w-1:0] awaddr,
   input  wire logic                              awvalid,
   input  wire logic [31:0]                       wdata,
   input  wire logic                              wvalid,
   input  wire logic                              bready,
   output logic                                   awready,
   output logic                                   wready,
   output logic                                   bvalid,
   output chess_pkg::wr_req_t                     wr
);

   logic        aw_full;
   logic        w_full;
   logic [7:0]  aw_word;
   logic [31:0] w_data;

   // Nothing new is taken while a response is pending
   assign awready = !aw_full && !bvalid;
   assign wready  = !w_full && !bvalid;

   always_comb
   begin
      wr.valid    = aw_full && w_full;    // Pulses once both halves are held
      wr.addr     = aw_word;
      wr.data.raw = w_data;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         aw_full <= 1'b0;
         w_full  <= 1'b0;
         bvalid  <= 1'b0;
      end
      else
      begin
         if (aw_full && w_full)
         begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b1;
         end
         else
         begin
            if (awvalid && awready)
               aw_full <= 1'b1;
            if (wvalid && wready)
               w_full <= 1'b1;
            if (bvalid && bready)
               bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (awvalid && awready)
         aw_word <= awaddr[9:2];    // Word address
      if (wvalid && wready)
         w_data <= wdata;
   end

endmodule

`default_nettype wire

/* logic/position_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module position_regs
(
   input  wire logic                              clk,
   input  wire logic                              rst_n,
   input  wire chess_pkg::wr_req_t                wr,
   input  wire logic [chess_pkg::axil_addr_w-1:0] araddr,
   input  wire logic                              arvalid,
   input  wire logic                              rready,
   output logic                                   arready,
   output logic [31:0]                            rdata,
   output logic                                   rvalid,
   input  wire logic                              busy,
   input  wire logic                              done,
   input  wire chess_pkg::eval_result_t           result,
   output logic                                   start,
   output chess_pkg::eval_cfg_t                   cfg
);

   chess_pkg::reg_word_u [chess_pkg::rank_count-1:0] board;
   logic                                             white_to_move;
   chess_pkg::eval_result_t                          res_q;
   logic                                             done_q;
   logic                                             ctrl_wr;
   logic [7:0]                                       wr_board_idx;
   logic [7:0]                                       rd_word;
   logic [7:0]                                       rd_board_idx;
   logic [31:0]                                      rd_data;

   assign ctrl_wr      = wr.valid && (wr.addr == chess_pkg::reg_ctrl);
   assign wr_board_idx = wr.addr - chess_pkg::reg_board_base;
   assign rd_word      = araddr[9:2];
   assign rd_board_idx = rd_word - chess_pkg::reg_board_base;
   assign arready      = !rvalid || rready;

   always_comb
   begin
      cfg.board         = board;
      cfg.white_to_move = white_to_move;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         board         <= '0;    // Empty board
         white_to_move <= 1'b1;
      end
      else if (wr.valid)
      begin
         if (wr.addr == chess_pkg::reg_side)
            white_to_move <= wr.data.raw[0];
         else if (wr_board_idx < chess_pkg::rank_count)
            board[wr_board_idx[2:0]] <= wr.data;
      end
   end

   // A new start also drops the done bit of the previous run
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         start  <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         start <= ctrl_wr && wr.data.raw[chess_pkg::ctrl_start];
         if (done)
            done_q <= 1'b1;
         else if (ctrl_wr && (wr.data.raw[chess_pkg::ctrl_start] ||
                              wr.data.raw[chess_pkg::ctrl_clear_done]))
            done_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         res_q <= '0;
      else if (done)
         res_q <= result;
   end

   always_comb
   begin
      rd_data = '0;
      case (rd_word)
         chess_pkg::reg_ctrl :
         begin
            rd_data[0] = busy;
            rd_data[1] = done_q;
            rd_data[2] = res_q.illegal;
         end
         chess_pkg::reg_side :
            rd_data[0] = white_to_move;
         chess_pkg::reg_pop :
         begin
            rd_data[13:8] = res_q.black_pop;
            rd_data[5:0]  = res_q.white_pop;
         end
         chess_pkg::reg_eval :
            rd_data = {{16{res_q.eval[15]}}, res_q.eval};    // Sign extended
         chess_pkg::reg_kings :
         begin
            rd_data[11:8] = res_q.black_kings;
            rd_data[3:0]  = res_q.white_kings;
         end
         default :
         begin
            if (rd_board_idx < chess_pkg::rank_count)
               rd_data = board[rd_board_idx[2:0]].raw;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rvalid <= 1'b0;
      else if (arvalid && arready)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (arvalid && arready)
         rdata <= rd_data;
   end

endmodule

`default_nettype wire

/* logic/position_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module position_eval
(
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    start,
   input  wire chess_pkg::eval_cfg_t    cfg,
   output logic                         busy,
   output logic                         done,
   output chess_pkg::eval_result_t      result
);

   logic [2:0]           rank;
   logic                 last_rank;
   chess_pkg::reg_word_u cur_rank;
   logic [3:0]           rank_white;
   logic [3:0]           rank_black;
   logic [3:0]           rank_wk;
   logic [3:0]           rank_bk;
   logic signed [15:0]   rank_mat;
   logic signed [15:0]   value;
   logic                 occupied;
   logic [6:0]           white_acc;
   logic [6:0]           black_acc;
   logic [6:0]           wk_acc;
   logic [6:0]           bk_acc;
   logic signed [15:0]   mat_acc;
   logic [6:0]           white_nxt;
   logic [6:0]           black_nxt;
   logic [6:0]           wk_nxt;
   logic [6:0]           bk_nxt;
   logic signed [15:0]   mat_nxt;

   // A full board holds 64 pieces
   function automatic logic [5:0] sat_pop(input logic [6:0] n);
      return n[6] ? 6'h3f : n[5:0];
   endfunction

   function automatic logic [3:0] sat_kings(input logic [6:0] n);
      return (n > 7'd15) ? 4'hf : n[3:0];
   endfunction

   assign last_rank = (rank == 3'(chess_pkg::rank_count - 1));
   assign cur_rank  = cfg.board[rank];

   always_comb
   begin
      rank_white = '0;
      rank_black = '0;
      rank_wk    = '0;
      rank_bk    = '0;
      rank_mat   = '0;
      value      = '0;
      occupied   = 1'b0;
      for (int i = 0; i < chess_pkg::rank_count; i++)
      begin
         case (cur_rank.sq[i].kind)
            chess_pkg::kind_pawn   : value = chess_pkg::pawn_value;
            chess_pkg::kind_knight : value = chess_pkg::knight_value;
            chess_pkg::kind_bishop : value = chess_pkg::bishop_value;
            chess_pkg::kind_rook   : value = chess_pkg::rook_value;
            chess_pkg::kind_queen  : value = chess_pkg::queen_value;
            chess_pkg::kind_king   : value = chess_pkg::king_value;
            default                : value = '0;
         endcase
         occupied = (cur_rank.sq[i].kind >= chess_pkg::kind_pawn) &&
                    (cur_rank.sq[i].kind <= chess_pkg::kind_king);    // 0 and 7 are empty
         if (occupied && cur_rank.sq[i].black)
         begin
            rank_black = rank_black + 4'd1;
            rank_mat   = rank_mat - value;
            if (cur_rank.sq[i].kind == chess_pkg::kind_king)
               rank_bk = rank_bk + 4'd1;
         end
         else if (occupied)
         begin
            rank_white = rank_white + 4'd1;
            rank_mat   = rank_mat + value;
            if (cur_rank.sq[i].kind == chess_pkg::kind_king)
               rank_wk = rank_wk + 4'd1;
         end
      end
   end

   assign white_nxt = white_acc + {3'b000, rank_white};
   assign black_nxt = black_acc + {3'b000, rank_black};
   assign wk_nxt    = wk_acc + {3'b000, rank_wk};
   assign bk_nxt    = bk_acc + {3'b000, rank_bk};
   assign mat_nxt   = mat_acc + rank_mat;    // White positive

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         busy <= 1'b0;
         done <= 1'b0;
         rank <= '0;
      end
      else
      begin
         done <= busy && last_rank;
         if (start && !busy)
         begin
            busy <= 1'b1;
            rank <= '0;
         end
         else if (busy)
         begin
            rank <= rank + 3'd1;
            if (last_rank)
               busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start && !busy)
      begin
         white_acc <= '0;
         black_acc <= '0;
         wk_acc    <= '0;
         bk_acc    <= '0;
         mat_acc   <= '0;
      end
      else if (busy)
      begin
         white_acc <= white_nxt;
         black_acc <= black_nxt;
         wk_acc    <= wk_nxt;
         bk_acc    <= bk_nxt;
         mat_acc   <= mat_nxt;
      end
      if (busy && last_rank)
      begin
         result.white_pop   <= sat_pop(white_nxt);
         result.black_pop   <= sat_pop(black_nxt);
         result.eval        <= cfg.white_to_move ? mat_nxt : -mat_nxt;    // Side to move view
         result.white_kings <= sat_kings(wk_nxt);
         result.black_kings <= sat_kings(bk_nxt);
         result.illegal     <= (wk_nxt != 7'd1) || (bk_nxt != 7'd1);
      end
   end

endmodule

`default_nettype wire

/* logic/chess_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module chess_ctrl_top
(
   input  wire logic                              clk,
   input  wire logic                              rst_n,
   input  wire logic [chess_pkg::axil_addr_w-1:0] awaddr,
   input  wire logic                              awvalid,
   output logic                                   awready,
   input  wire logic [31:0]                       wdata,
   input  wire logic [3:0]                        wstrb,    // Full words only
   input  wire logic                              wvalid,
   output logic                                   wready,
   output logic [1:0]                             bresp,
   output logic                                   bvalid,
   input  wire logic                              bready,
   input  wire logic [chess_pkg::axil_addr_w-1:0] araddr,
   input  wire logic                              arvalid,
   output logic                                   arready,
   output logic [31:0]                            rdata,
   output logic [1:0]                             rresp,
   output logic                                   rvalid,
   input  wire logic                              rready
);

   chess_pkg::wr_req_t      wr;
   chess_pkg::eval_cfg_t    cfg;
   chess_pkg::eval_result_t result;
   logic                    start;
   logic                    busy;
   logic                    done;

   assign bresp = chess_pkg::axi_resp_okay;
   assign rresp = chess_pkg::axi_resp_okay;

   axil_write_port axil_write_port_i
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .bready  (bready),
      .awready (awready),
      .wready  (wready),
      .bvalid  (bvalid),
      .wr      (wr)
   );

   position_regs position_regs_i
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr      (wr),
      .araddr  (araddr),
      .arvalid (arvalid),
      .rready  (rready),
      .arready (arready),
      .rdata   (rdata),
      .rvalid  (rvalid),
      .busy    (busy),
      .done    (done),
      .result  (result),
      .start   (start),
      .cfg     (cfg)
   );

   position_eval position_eval_i
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (start),
      .cfg    (cfg),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

endmodule

`default_nettype wire

/* bench/chess_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module chess_ctrl_tb;

   localparam int half_period = 20;
   localparam int resp_limit = 32;    // Cycles allowed for one handshake
   localparam int poll_limit = 40;

   logic        clk;
   logic        rst_n;
   logic [11:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [11:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   int mismatches = 0;
   int failures = 0;
   int trace_lines = 0;

   chess_ctrl_top chess_ctrl_top_i
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   always #(half_period) clk = ~clk;

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      mismatches++;
   endtask

   // Outputs are sampled at the rising edge, before the DUT updates
   task automatic axi_write(input logic [11:0] addr, input logic [31:0] data, input int hold);
      int   cycles;
      int   i;
      logic aw_done;
      logic w_done;
      aw_done = 1'b0;
      w_done  = 1'b0;
      cycles  = 0;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      bready  <= (hold == 0);
      while (!(aw_done && w_done) && cycles < resp_limit)
      begin
         @(posedge clk);
         cycles++;
         if (awvalid && awready)
         begin
            aw_done = 1'b1;
            awvalid <= 1'b0;
         end
         if (wvalid && wready)
         begin
            w_done = 1'b1;
            wvalid <= 1'b0;
         end
      end
      if (!(aw_done && w_done))
      begin
         $display("write to %h was never accepted", addr);
         failures++;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
      end
      cycles = 0;
      while (!bvalid && cycles < resp_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!bvalid)
      begin
         $display("write to %h got no write response", addr);
         failures++;
      end
      else
      begin
         for (i = 0; i < hold; i++)
         begin
            if (bvalid !== 1'b1)
               report_mismatch("bvalid", 32'h1, {31'h0, bvalid});
            if (awready !== 1'b0)
               report_mismatch("awready", 32'h0, {31'h0, awready});
            if (wready !== 1'b0)
               report_mismatch("wready", 32'h0, {31'h0, wready});
            @(posedge clk);
         end
         if (hold > 0)
         begin
            bready <= 1'b1;    // Response taken on the next edge
            @(posedge clk);
         end
         if (bresp !== 2'b00)
            report_mismatch("bresp", 32'h0, {30'h0, bresp});
      end
      bready <= 1'b1;
   endtask

   task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
      int cycles;
      cycles = 0;
      data   = 'x;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      do
      begin
         @(posedge clk);
         cycles++;
      end
      while (!arready && cycles < resp_limit);
      arvalid <= 1'b0;
      while (!rvalid && cycles < resp_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!rvalid)
      begin
         $display("read of %h got no read data", addr);
         failures++;
      end
      else
      begin
         data = rdata;
         if (rresp !== 2'b00)
            report_mismatch("rresp", 32'h0, {30'h0, rresp});
      end
   endtask

   task automatic poll_done();
      logic [31:0] status;
      int          polls;
      status = '0;
      polls  = 0;
      while (status[1] !== 1'b1 && polls < poll_limit)
      begin
         axi_read({2'b00, chess_pkg::reg_ctrl, 2'b00}, status);
         polls++;
      end
      if (status[1] !== 1'b1)
      begin
         $display("done never came up in %0d polls of the control register", polls);
         failures++;
      end
   endtask

   // Watchdog sized from the trace length
   initial
   begin
      wait (trace_lines > 0);
      repeat (trace_lines * 100) @(posedge clk);
      $display("watchdog expired after %0d cycles, trace did not finish", trace_lines * 100);
      $display("Test FAILED");
      $finish;
   end

   initial
   begin
      int          fd;
      int          r;
      int          n;
      int          hold_next;
      string       cmd;
      string       line;
      logic [31:0] addr;
      logic [31:0] value;
      logic [31:0] got;
      clk       = 1'b0;
      rst_n     = 1'b0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = 4'hf;
      wvalid    = 1'b0;
      bready    = 1'b1;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b1;
      hold_next = 0;
      n         = 0;
      fd = $fopen("bench/chess_ctrl_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the trace file bench/chess_ctrl_trace.txt");
         failures++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            r = $fgets(line, fd);
            if (r != 0)
               n++;
         end
         $fclose(fd);
         trace_lines = n;
         fd = $fopen("bench/chess_ctrl_trace.txt", "r");
         repeat (10) @(posedge clk);
         rst_n <= 1'b1;
         while ($fscanf(fd, "%s", cmd) == 1)
         begin
            if (cmd.substr(0, 0) == "#")
               r = $fgets(line, fd);    // Skip the rest of a comment
            else if (cmd == "W")
            begin
               r = $fscanf(fd, "%h %h", addr, value);
               axi_write(addr[11:0], value, hold_next);
               hold_next = 0;
            end
            else if (cmd == "R")
            begin
               r = $fscanf(fd, "%h %h", addr, value);
               axi_read(addr[11:0], got);
               if (got !== value)
                  report_mismatch($sformatf("rdata[%03h]", addr[11:0]), value, got);
            end
            else if (cmd == "P")
               poll_done();
            else if (cmd == "B")
               r = $fscanf(fd, "%d", hold_next);
            else
            begin
               $display("unknown trace command %s", cmd);
               failures++;
            end
         end
         $fclose(fd);
      end
      $display("errors: %0d mismatches, %0d protocol failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/chess_ctrl_trace.txt */
# W addr data: write, R addr expected: read and compare, P: poll ctrl until done,
# B n: hold bready low n cycles on the next write; addresses and data in hex
R 004 00000001
R 000 00000000
R 020 00000000
R 03C 00000000
W 020 12345678
R 020 12345678
W 03C F7A9C0E1
R 03C F7A9C0E1
W 004 00000000
R 004 00000000
W 004 00000001
W 00C DEADBEEF
R 00C 00000000
R 100 00000000
# Starting position, rank 1 at 020
W 020 42365324
W 024 11111111
W 028 00000000
W 02C 00000000
W 030 00000000
W 034 00000000
W 038 99999999
W 03C CABEDBAC
W 000 00000001
P
R 000 00000002
R 040 00001010
R 044 00000000
R 048 00000101
# White queen on d3 and black pawn on a6
W 028 00005000
W 034 00000009
W 000 00000001
P
R 040 00001111
R 044 00000008
W 004 00000000
W 000 00000001
P
R 044 FFFFFFF8
W 004 00000001
# Second white king on h3
W 028 60000000
W 034 00000000
W 000 00000001
P
R 000 00000006
R 048 00000102
W 000 00000002
R 000 00000004
# No black king
W 028 00000000
W 03C CAB0DBAC
W 000 00000001
P
R 000 00000006
R 048 00000001
R 040 00000F10
# Write response held back
B 4
W 03C CABEDBAC
W 02C 00000050
R 03C CABEDBAC
R 02C 00000050
W 000 00000001
P
R 000 00000002
R 044 00000009

/* list.f */
logic/chess_pkg.sv
logic/axil_write_port.sv
logic/position_regs.sv
logic/position_eval.sv
logic/chess_ctrl_top.sv
bench/chess_ctrl_tb.sv

/* Bender.yml */
package:
  name: chess_ctrl

sources:
  - files:
      - logic/chess_pkg.sv
      - logic/axil_write_port.sv
      - logic/position_regs.sv
      - logic/position_eval.sv
      - logic/chess_ctrl_top.sv
  - target: test
    files:
      - bench/chess_ctrl_tb.sv
